/* Bender.yml */
package:
  name: memSystem

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/memPkg.sv
      - hdl/pageBus.sv
      - hdl/addressDecoder.sv
      - hdl/ramPage.sv
      - hdl/vectorRom.sv
      - hdl/readMux.sv
      - hdl/memSystem.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tbClock.sv
      - tests/memSystem_assertions.sv
      - tests/memSystem_tb.sv

/* compile.f */
+incdir+include
hdl/memPkg.sv
hdl/pageBus.sv
hdl/addressDecoder.sv
hdl/ramPage.sv
hdl/vectorRom.sv
hdl/readMux.sv
hdl/memSystem.sv
tests/tbClock.sv
tests/memSystem_assertions.sv
tests/memSystem_tb.sv

/* hdl/addressDecoder.sv */
`include "mem_params.svh"

module addressDecoder
(
  input  memPkg::busByte    addressBusHigh,
  input  memPkg::busByte    addressBusLow,
  input  memPkg::busByte    dataBusOutput,
  input  logic              readNotWrite,
  pageBus.decoder           pages [`RAM_PAGES],
  output memPkg::regionType region,
  output memPkg::pageIndex  selectedPage
);
  import memPkg::*;

  // high byte alone picks the region
  always_comb
  begin
    if (addressBusHigh >= `ROM_BASE)
    begin
      region = regionRom;
    end
    else if (addressBusHigh < busByte'(`RAM_PAGES))
    begin
      region = regionRam;
    end
    else
    begin
      // below rom but past the last page
      region = regionUnmapped;
    end
  end

  // page number is the high byte, only meaningful in the ram region
  assign selectedPage = pageIndex'(addressBusHigh);

  // per-page strobe plus shared offset and data
  for (genvar i = 0; i < `RAM_PAGES; i++)
  begin : strobeGen
    // one page at most, and only when writing to ram
    assign pages[i].writeStrobe = !readNotWrite
                                  && (region == regionRam)
                                  && (addressBusHigh == busByte'(i));

    // low nibble picks the byte, upper nibble mirrors
    assign pages[i].offset = pageOffset'(addressBusLow);

    // same write data goes to every page
    assign pages[i].writeData = dataBusOutput;
  end

endmodule

/* hdl/memPkg.sv */
`include "mem_params.svh"

package memPkg;

  // one byte of address or data on the processor bus
  typedef logic [7:0] busByte;

  // byte position within a page
  localparam int offsetBits = $clog2(`PAGE_BYTES);
  typedef logic [offsetBits-1:0] pageOffset;

  // page selector, kept at least one bit wide for a single-page build
  localparam int pageIdxBits = (`RAM_PAGES > 1) ? $clog2(`RAM_PAGES) : 1;
  typedef logic [pageIdxBits-1:0] pageIndex;

  // where an access lands in the memory map
  typedef enum logic [1:0]
  {
    regionRam,
    regionUnmapped,
    regionRom
  } regionType;

endpackage

/* hdl/memSystem.sv */
`include "mem_params.svh"

module memSystem
(
  input  logic           clk,
  input  logic           nrst,
  input  memPkg::busByte addressBusHigh,
  input  memPkg::busByte addressBusLow,
  input  memPkg::busByte dataBusOutput,
  input  logic           readNotWrite,
  output memPkg::busByte dataBusInput
);
  import memPkg::*;

  // decoder results for the read mux
  regionType region;
  pageIndex  selectedPage;

  // vector rom output before direction gating
  busByte romData;

  // one link per ram page
  pageBus pageLinks [`RAM_PAGES] ();

  // region and strobe decode
  addressDecoder decoder
  (
    .addressBusHigh(addressBusHigh),
    .addressBusLow(addressBusLow),
    .dataBusOutput(dataBusOutput),
    .readNotWrite(readNotWrite),
    .pages(pageLinks),
    .region(region),
    .selectedPage(selectedPage)
  );

  // identical pages, each on its own link
  for (genvar i = 0; i < `RAM_PAGES; i++)
  begin : pageGen
    ramPage
    #(
      .pageNumber(i)
    )
    page
    (
      .clk(clk),
      .nrst(nrst),
      .bus(pageLinks[i])
    );
  end

  // fixed vectors at the top of the map
  vectorRom rom
  (
    .addressBusLow(addressBusLow),
    .addressBusHigh(addressBusHigh),
    .romData(romData)
  );

  // final read data select
  readMux mux
  (
    .region(region),
    .selectedPage(selectedPage),
    .readNotWrite(readNotWrite),
    .pages(pageLinks),
    .romData(romData),
    .dataBusInput(dataBusInput)
  );

endmodule

/* hdl/pageBus.sv */
// link between the decoder, one ram page and the read mux
interface pageBus;
  import memPkg::*;

  // high for one cycle when this page takes a write
  logic writeStrobe;

  // byte within the page, shared by reads and writes
  pageOffset offset;

  // byte to store on a write
  busByte writeData;

  // combinational read of the addressed byte
  busByte readData;

  // decoder drives the access, never looks back
  modport decoder (output writeStrobe, output offset, output writeData);

  // page stores on strobe and answers with its byte
  modport page (input writeStrobe, input offset, input writeData, output readData);

  // read mux only collects data
  modport reader (input readData);

endinterface

/* hdl/ramPage.sv */
`include "mem_params.svh"

module ramPage
#(
  // index of this page in the map, for labelling checks
  parameter int pageNumber = 0
)
(
  input logic clk,
  input logic nrst,
  pageBus.page bus
);
  import memPkg::*;

  // page storage
  busByte mem [`PAGE_BYTES];

  // clocked write, whole page cleared while in reset
  always_ff @(posedge clk, negedge nrst)
  begin
    if (!nrst)
    begin
      for (int i = 0; i < `PAGE_BYTES; i++)
      begin
        mem[i] <= '0;
      end
    end
    else if (bus.writeStrobe)
    begin
      mem[bus.offset] <= bus.writeData;
    end
  end

  // read is combinational, no latency
  // the read mux decides whether it reaches the bus
  assign bus.readData = mem[bus.offset];

endmodule

/* hdl/readMux.sv */
`include "mem_params.svh"

module readMux
(
  input  memPkg::regionType region,
  input  memPkg::pageIndex  selectedPage,
  input  logic              readNotWrite,
  pageBus.reader            pages [`RAM_PAGES],
  input  memPkg::busByte    romData,
  output memPkg::busByte    dataBusInput
);
  import memPkg::*;

  // page outputs gathered into a plain array for variable indexing
  busByte pageData [`RAM_PAGES];

  for (genvar i = 0; i < `RAM_PAGES; i++)
  begin : gatherGen
    assign pageData[i] = pages[i].readData;
  end

  // source select by region, bus held at zero while writing
  always_comb
  begin
    if (!readNotWrite)
    begin
      // write cycle, processor owns the data lines
      dataBusInput = '0;
    end
    else
    begin
      case (region)
        regionRam:
          dataBusInput = pageData[selectedPage];
        regionRom:
          dataBusInput = romData;
        // unmapped reads float to zero
        default:
          dataBusInput = '0;
      endcase
    end
  end

endmodule

/* hdl/vectorRom.sv */
`include "mem_params.svh"

module vectorRom
(
  input  memPkg::busByte addressBusLow,
  input  memPkg::busByte addressBusHigh,
  output memPkg::busByte romData
);
  import memPkg::*;

  // full 16-bit address for the lookup
  logic [15:0] address;

  assign address = {addressBusHigh, addressBusLow};

  // six vector bytes, everything else in rom reads as zero
  always_comb
  begin
    case (address)
      `VEC_NMI_ADDR:
        romData = `VEC_NMI_LO;
      `VEC_NMI_ADDR + 16'd1:
        romData = `VEC_NMI_HI;
      // reset vector, the first fetch after reset
      `VEC_RST_ADDR:
        romData = `VEC_RST_LO;
      `VEC_RST_ADDR + 16'd1:
        romData = `VEC_RST_HI;
      `VEC_IRQ_ADDR:
        romData = `VEC_IRQ_LO;
      `VEC_IRQ_ADDR + 16'd1:
        romData = `VEC_IRQ_HI;
      default:
        romData = busByte'(0);
    endcase
  end

endmodule

/* include/mem_params.svh */
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// number of writable ram pages, starting at page 0x00
`define RAM_PAGES 2

// bytes per ram page, selected by the low nibble of the address
`define PAGE_BYTES 16

// high byte where the vector rom region begins
`define ROM_BASE 8'h80

// full addresses of the vector bytes at the top of the map
`define VEC_NMI_ADDR 16'hFFFA
`define VEC_RST_ADDR 16'hFFFC
`define VEC_IRQ_ADDR 16'hFFFE

// vector contents, low byte first as the 6502 fetches them
`define VEC_NMI_LO 8'hAA
`define VEC_NMI_HI 8'hBB
`define VEC_RST_LO 8'hCC
`define VEC_RST_HI 8'hDD
`define VEC_IRQ_LO 8'hEE
`define VEC_IRQ_HI 8'hFF

`endif

/* tests/memSystem_assertions.sv */
`include "mem_params.svh"

module memSystem_assertions
(
  input logic           clk,
  input logic           nrst,
  input memPkg::busByte addressBusHigh,
  input memPkg::busByte addressBusLow,
  input logic           readNotWrite,
  input memPkg::busByte dataBusInput,
  pageBus               links [`RAM_PAGES]
);
  import memPkg::*;

  // assertion failures so far
  int failCount = 0;

  logic [15:0] address;
  logic [`RAM_PAGES-1:0] strobes;

  assign address = {addressBusHigh, addressBusLow};

  // strobes gathered into one vector
  for (genvar i = 0; i < `RAM_PAGES; i++)
  begin : strobeGather
    assign strobes[i] = links[i].writeStrobe;
  end

  // vector table at the top of the map
  function automatic busByte vectorByte(input logic [15:0] addr);
    case (addr)
      16'hFFFA: return `VEC_NMI_LO;
      16'hFFFB: return `VEC_NMI_HI;
      16'hFFFC: return `VEC_RST_LO;
      16'hFFFD: return `VEC_RST_HI;
      16'hFFFE: return `VEC_IRQ_LO;
      default: return `VEC_IRQ_HI;
    endcase
  endfunction

  // processor drives the data lines during a write
  writeIdle: assert property (@(posedge clk) disable iff (!nrst)
    !readNotWrite |-> dataBusInput == '0)
  else
  begin
    failCount++;
    $error("read data bus not zero during a write cycle");
  end

  // reads and non-ram writes leave every page alone
  noStrobeOutsideRam: assert property (@(posedge clk) disable iff (!nrst)
    (readNotWrite || addressBusHigh >= busByte'(`RAM_PAGES)) |-> strobes == '0)
  else
  begin
    failCount++;
    $error("write strobe raised outside a ram page write");
  end

  oneStrobeAtMost: assert property (@(posedge clk) disable iff (!nrst)
    $onehot0(strobes))
  else
  begin
    failCount++;
    $error("more than one page strobed in the same cycle");
  end

  // vector bytes never change
  fixedVectors: assert property (@(posedge clk) disable iff (!nrst)
    (readNotWrite && address >= 16'hFFFA) |-> dataBusInput == vectorByte(address))
  else
  begin
    failCount++;
    $error("vector byte read back with the wrong value");
  end

endmodule

/* tests/memSystem_tb.sv */
`include "mem_params.svh"

module memSystem_tb;
  import memPkg::*;

  // one read per byte of every page
  localparam int pageCycles = `RAM_PAGES * `PAGE_BYTES;

  // reset, write/read, unmapped, rom and random phases
  localparam int plannedCycles = pageCycles
    + `RAM_PAGES * (2 * `PAGE_BYTES + pageCycles * 16)
    + 2 * (128 - `RAM_PAGES) + pageCycles
    + 16 + 128 + 12 + 2 + pageCycles
    + 400;
  localparam int watchdogTime = (plannedCycles + 100) * 10;

  logic   clk;
  logic   nrst;
  busByte addressBusHigh;
  busByte addressBusLow;
  busByte dataBusOutput;
  logic   readNotWrite;
  busByte dataBusInput;

  int valueErrors;
  logic [31:0] lfsrState;

  // expected contents of every ram page
  busByte shadow [`RAM_PAGES][`PAGE_BYTES];

  tbClock clockGen
  (
    .clk(clk),
    .nrst(nrst)
  );

  memSystem UUT
  (
    .clk(clk),
    .nrst(nrst),
    .addressBusHigh(addressBusHigh),
    .addressBusLow(addressBusLow),
    .dataBusOutput(dataBusOutput),
    .readNotWrite(readNotWrite),
    .dataBusInput(dataBusInput)
  );

  bind memSystem memSystem_assertions checks
  (
    .clk(clk),
    .nrst(nrst),
    .addressBusHigh(addressBusHigh),
    .addressBusLow(addressBusLow),
    .readNotWrite(readNotWrite),
    .dataBusInput(dataBusInput),
    .links(pageLinks)
  );

  // right-shift galois lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] state);
    if (state[0])
    begin
      return (state >> 1) ^ 32'h80200003;
    end
    return state >> 1;
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] randomBits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++)
    begin
      lfsrState = lfsrNext(lfsrState);
      value = {value[30:0], lfsrState[0]};
    end
    return value;
  endfunction

  function automatic busByte romExpected(input logic [15:0] address);
    case (address)
      16'hFFFA: return `VEC_NMI_LO;
      16'hFFFB: return `VEC_NMI_HI;
      16'hFFFC: return `VEC_RST_LO;
      16'hFFFD: return `VEC_RST_HI;
      16'hFFFE: return `VEC_IRQ_LO;
      16'hFFFF: return `VEC_IRQ_HI;
      default: return 8'h00;
    endcase
  endfunction

  // zero on writes and unmapped reads
  function automatic busByte expectedData(input busByte high, input busByte low,
                                          input logic rnw);
    if (!rnw)
    begin
      return 8'h00;
    end
    if (high >= `ROM_BASE)
    begin
      return romExpected({high, low});
    end
    if (high < busByte'(`RAM_PAGES))
    begin
      return shadow[pageIndex'(high)][low[3:0]];
    end
    return 8'h00;
  endfunction

  // one bus cycle entered and left 1 unit after a rising edge
  task automatic busCycle(input busByte high, input busByte low, input busByte data,
                          input logic rnw);
    busByte expected;
    addressBusHigh = high;
    addressBusLow = low;
    dataBusOutput = data;
    readNotWrite = rnw;
    // sample just before the closing edge
    #8;
    expected = expectedData(high, low, rnw);
    assert (dataBusInput === expected)
    else
    begin
      valueErrors++;
      $display("ERROR t=%0t dataBusInput expected=%02h actual=%02h",
               $time, expected, dataBusInput);
    end
    @(posedge clk);
    // write lands on this edge
    if (!rnw && high < busByte'(`RAM_PAGES))
    begin
      shadow[pageIndex'(high)][low[3:0]] = data;
    end
    #1;
  endtask

  task automatic writeByte(input busByte high, input busByte low, input busByte data);
    busCycle(high, low, data, 1'b0);
  endtask

  task automatic readByte(input busByte high, input busByte low);
    busCycle(high, low, 8'h00, 1'b1);
  endtask

  // read every byte of every page through the first few mirrors
  task automatic sweepPages(input int mirrors);
    for (int p = 0; p < `RAM_PAGES; p++)
    begin
      for (int m = 0; m < mirrors; m++)
      begin
        for (int o = 0; o < `PAGE_BYTES; o++)
        begin
          readByte(busByte'(p), busByte'((m << 4) | o));
        end
      end
    end
  endtask

  // each write read back in the next cycle via another mirror
  task automatic checkWriteRead();
    busByte data;
    busByte mirror;
    for (int p = 0; p < `RAM_PAGES; p++)
    begin
      for (int o = 0; o < `PAGE_BYTES; o++)
      begin
        // never zero so a lost write shows up
        data = busByte'(randomBits(8)) | 8'h01;
        mirror = busByte'(randomBits(4)) << 4;
        writeByte(busByte'(p), mirror | busByte'(o), data);
        mirror = busByte'(randomBits(4)) << 4;
        readByte(busByte'(p), mirror | busByte'(o));
      end
      // all mirrors of every page, other pages included
      sweepPages(16);
    end
  endtask

  task automatic checkUnmapped();
    busByte low;
    for (int h = `RAM_PAGES; h < 'h80; h++)
    begin
      low = busByte'(randomBits(8));
      writeByte(busByte'(h), low, busByte'(randomBits(8)) | 8'h01);
      readByte(busByte'(h), low);
    end
    sweepPages(1);
  endtask

  task automatic checkRom();
    // top 16 bytes hold the six vectors
    for (int i = 0; i < 16; i++)
    begin
      readByte(8'hFF, 8'hF0 | busByte'(i));
    end
    // one read per rom page
    for (int h = 'h80; h < 'h100; h++)
    begin
      readByte(busByte'(h), busByte'(randomBits(8)));
    end
    for (int i = 'hFA; i < 'h100; i++)
    begin
      writeByte(8'hFF, busByte'(i), busByte'(randomBits(8)) | 8'h01);
    end
    for (int i = 'hFA; i < 'h100; i++)
    begin
      readByte(8'hFF, busByte'(i));
    end
    // low rom pages alias ram page numbers in their bottom bits
    writeByte(`ROM_BASE, busByte'(randomBits(8)), 8'hA5);
    writeByte(`ROM_BASE + 8'h01, busByte'(randomBits(8)), 8'h5A);
    sweepPages(1);
  endtask

  // mix of ram, unmapped, rom and vector accesses
  task automatic runRandom(input int cycles);
    logic [1:0] kind;
    busByte high;
    busByte low;
    logic rnw;
    for (int n = 0; n < cycles; n++)
    begin
      kind = 2'(randomBits(2));
      case (kind)
        2'd0: high = busByte'(randomBits(8) % `RAM_PAGES);
        2'd1: high = busByte'(`RAM_PAGES + randomBits(8) % (128 - `RAM_PAGES));
        2'd2: high = `ROM_BASE | busByte'(randomBits(7));
        default: high = 8'hFF;
      endcase
      low = busByte'(randomBits(8));
      if (kind == 2'd3)
      begin
        low = 8'hF8 | busByte'(randomBits(3));
      end
      rnw = (randomBits(1) != 0);
      busCycle(high, low, busByte'(randomBits(8)), rnw);
    end
  endtask

  initial
  begin
    addressBusHigh = 8'h00;
    addressBusLow = 8'h00;
    dataBusOutput = 8'h00;
    readNotWrite = 1'b1;
    valueErrors = 0;
    lfsrState = 32'h4736;
    for (int p = 0; p < `RAM_PAGES; p++)
    begin
      for (int o = 0; o < `PAGE_BYTES; o++)
      begin
        shadow[p][o] = 8'h00;
      end
    end
    @(posedge nrst);
    // pages come out of reset cleared
    sweepPages(1);
    checkWriteRead();
    checkUnmapped();
    checkRom();
    runRandom(400);
    $display("value errors: %0d, assertion errors: %0d", valueErrors, UUT.checks.failCount);
    if (valueErrors == 0 && UUT.checks.failCount == 0)
    begin
      $display("Result: PASSED");
    end
    else
    begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // stops a run that never reaches the end of the tests
  initial
  begin
    #(watchdogTime);
    $display("timeout: tests still running after %0d time units", watchdogTime);
    $display("Result: FAILED");
    $finish;
  end

endmodule

/* tests/tbClock.sv */
module tbClock
(
  output logic clk,
  output logic nrst
);

  // free-running clock, period 10
  initial
  begin
    clk = 1'b0;
    forever
    begin
      #5 clk = ~clk;
    end
  end

  // reset low for four rising edges, released just after the fourth
  initial
  begin
    nrst = 1'b0;
    repeat (4)
    begin
      @(posedge clk);
    end
    #1 nrst = 1'b1;
  end

endmodule
